// File: hw/apb_capture_regs.sv
/*
 * APB slave with per-channel control registers, status words
 * and a read-only window onto the capture buffer
 */

module apb_capture_regs (
  input  logic                                   clk,
  input  logic                                   rst,

  // APB slave
  input  logic                                   i_psel,
  input  logic                                   i_penable,
  input  logic                                   i_pwrite,
  input  logic [stream_regs_pkg::APB_AW-1:0]     i_paddr,
  input  logic [stream_cfg_pkg::DATA_W-1:0]      i_pwdata,
  output logic [stream_cfg_pkg::DATA_W-1:0]      o_prdata,
  output logic                                   o_pready,
  output logic                                   o_pslverr,

  // channel control
  output logic                                   o_enable0,
  output logic [stream_cfg_pkg::TDEST_W-1:0]     o_dest0,
  output logic                                   o_enable1,
  output logic [stream_cfg_pkg::TDEST_W-1:0]     o_dest1,

  // channel status
  input  logic [stream_cfg_pkg::CNT_W-1:0]       i_kept0,
  input  logic [stream_cfg_pkg::CNT_W-1:0]       i_dropped0,
  input  logic [stream_cfg_pkg::REGION_AW-1:0]   i_ptr0,
  input  logic [stream_cfg_pkg::CNT_W-1:0]       i_kept1,
  input  logic [stream_cfg_pkg::CNT_W-1:0]       i_dropped1,
  input  logic [stream_cfg_pkg::REGION_AW-1:0]   i_ptr1,

  // buffer read port
  output logic                                   o_rd_en,
  output logic [stream_cfg_pkg::BUF_AW-1:0]      o_rd_addr,
  input  logic [stream_cfg_pkg::DATA_W-1:0]      i_rd_data
);

  logic                                 access;
  logic                                 is_ctrl0;
  logic                                 is_ctrl1;
  logic                                 is_stat0;
  logic                                 is_stat1;
  logic                                 is_buf;
  logic                                 is_reg;
  logic                                 buf_rd;
  logic                                 rd_wait;
  logic                                 err;
  logic [stream_cfg_pkg::DATA_W-1:0]    ctrl0_word;
  logic [stream_cfg_pkg::DATA_W-1:0]    ctrl1_word;
  logic [stream_cfg_pkg::DATA_W-1:0]    stat0_word;
  logic [stream_cfg_pkg::DATA_W-1:0]    stat1_word;

  // address decode
  assign access = i_psel & i_penable;
  assign is_ctrl0 = (i_paddr == stream_regs_pkg::ADDR_CTRL0);
  assign is_ctrl1 = (i_paddr == stream_regs_pkg::ADDR_CTRL1);
  assign is_stat0 = (i_paddr == stream_regs_pkg::ADDR_STAT0);
  assign is_stat1 = (i_paddr == stream_regs_pkg::ADDR_STAT1);
  assign is_buf = (i_paddr >= stream_regs_pkg::BUF_WIN_BASE);
  assign is_reg = is_ctrl0 | is_ctrl1 | is_stat0 | is_stat1;

  // buffer read issued in the first access cycle
  assign buf_rd = access & ~i_pwrite & is_buf;
  assign o_rd_en = buf_rd & ~rd_wait;
  assign o_rd_addr = i_paddr[stream_cfg_pkg::BUF_AW+1:2];

  // single wait state while the buffer read lands
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_wait <= 1'b0;
    end else begin
      rd_wait <= o_rd_en;
    end
  end

  assign o_pready = access & (~buf_rd | rd_wait);

  // writes only land on control regs
  // status writes are quietly ignored
  assign err = i_pwrite ? ~is_reg : ~(is_reg | is_buf);
  assign o_pslverr = o_pready & err;

  // control registers, written at the access edge
  always_ff @(posedge clk) begin
    if (rst) begin
      o_enable0 <= 1'b0;
      o_dest0 <= '0;
      o_enable1 <= 1'b0;
      o_dest1 <= '0;
    end else if (access && i_pwrite) begin
      if (is_ctrl0) begin
        o_enable0 <= i_pwdata[stream_regs_pkg::CTRL_EN_BIT];
        o_dest0 <= i_pwdata[stream_regs_pkg::CTRL_DEST_LSB +: stream_cfg_pkg::TDEST_W];
      end
      if (is_ctrl1) begin
        o_enable1 <= i_pwdata[stream_regs_pkg::CTRL_EN_BIT];
        o_dest1 <= i_pwdata[stream_regs_pkg::CTRL_DEST_LSB +: stream_cfg_pkg::TDEST_W];
      end
    end
  end

  // readback words
  always_comb begin
    ctrl0_word = '0;
    ctrl1_word = '0;
    stat0_word = '0;
    stat1_word = '0;
    ctrl0_word[stream_regs_pkg::CTRL_EN_BIT] = o_enable0;
    ctrl0_word[stream_regs_pkg::CTRL_DEST_LSB +: stream_cfg_pkg::TDEST_W] = o_dest0;
    ctrl1_word[stream_regs_pkg::CTRL_EN_BIT] = o_enable1;
    ctrl1_word[stream_regs_pkg::CTRL_DEST_LSB +: stream_cfg_pkg::TDEST_W] = o_dest1;
    stat0_word[stream_regs_pkg::STAT_KEPT_LSB +: stream_cfg_pkg::CNT_W] = i_kept0;
    stat0_word[stream_regs_pkg::STAT_DROP_LSB +: stream_cfg_pkg::CNT_W] = i_dropped0;
    stat0_word[stream_regs_pkg::STAT_PTR_LSB +: stream_cfg_pkg::REGION_AW] = i_ptr0;
    stat1_word[stream_regs_pkg::STAT_KEPT_LSB +: stream_cfg_pkg::CNT_W] = i_kept1;
    stat1_word[stream_regs_pkg::STAT_DROP_LSB +: stream_cfg_pkg::CNT_W] = i_dropped1;
    stat1_word[stream_regs_pkg::STAT_PTR_LSB +: stream_cfg_pkg::REGION_AW] = i_ptr1;
  end

  // read mux, unmapped reads give zero
  always_comb begin
    o_prdata = '0;
    if (access && !i_pwrite) begin
      if (is_ctrl0) begin
        o_prdata = ctrl0_word;
      end else if (is_ctrl1) begin
        o_prdata = ctrl1_word;
      end else if (is_stat0) begin
        o_prdata = stat0_word;
      end else if (is_stat1) begin
        o_prdata = stat1_word;
      end else if (is_buf) begin
        o_prdata = i_rd_data;
      end
    end
  end

endmodule

// File: hw/axis_ingress.sv
/*
 * stream slave for one capture channel: tdest filter, keep masking,
 * one-word holding stage toward the buffer arbiter, frame counters
 */

module axis_ingress (
  input  logic                                   clk,
  input  logic                                   rst,

  // channel configuration
  input  logic                                   i_enable,
  input  logic [stream_cfg_pkg::TDEST_W-1:0]     i_dest,

  // stream slave
  input  logic                                   i_tvalid,
  output logic                                   o_tready,
  input  logic [stream_cfg_pkg::DATA_W-1:0]      i_tdata,
  input  logic [stream_cfg_pkg::KEEP_W-1:0]      i_tkeep,
  input  logic                                   i_tlast,
  input  logic [stream_cfg_pkg::TDEST_W-1:0]     i_tdest,

  // toward the write arbiter
  output logic                                   o_req,
  output logic [stream_cfg_pkg::REGION_AW-1:0]   o_off,
  output logic [stream_cfg_pkg::DATA_W-1:0]      o_data,
  input  logic                                   i_gnt,

  // status
  output logic [stream_cfg_pkg::CNT_W-1:0]       o_kept,
  output logic [stream_cfg_pkg::CNT_W-1:0]       o_dropped,
  output logic [stream_cfg_pkg::REGION_AW-1:0]   o_ptr
);

  logic                                   hold_valid;
  logic [stream_cfg_pkg::DATA_W-1:0]      hold_data;
  logic [stream_cfg_pkg::REGION_AW-1:0]   wr_ptr;
  logic [stream_cfg_pkg::CNT_W-1:0]       kept_cnt;
  logic [stream_cfg_pkg::CNT_W-1:0]       drop_cnt;
  logic                                   accept;
  logic                                   dest_match;
  logic [stream_cfg_pkg::DATA_W-1:0]      masked_data;

  // ready only while enabled with an empty holding stage
  assign o_tready = i_enable & ~hold_valid;
  assign accept = i_tvalid & o_tready;
  assign dest_match = (i_tdest == i_dest);

  // zero the bytes tkeep does not mark
  always_comb begin
    for (int b = 0; b < stream_cfg_pkg::KEEP_W; b++) begin
      masked_data[b*8 +: 8] = i_tdata[b*8 +: 8] & {8{i_tkeep[b]}};
    end
  end

  // holding stage flag
  // set on a matching beat, cleared on grant
  // both cannot happen together, req is low while empty
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_valid <= 1'b0;
    end else if (accept && dest_match) begin
      hold_valid <= 1'b1;
    end else if (i_gnt) begin
      hold_valid <= 1'b0;
    end
  end

  // payload of the holding stage
  always_ff @(posedge clk) begin
    if (accept && dest_match) begin
      hold_data <= masked_data;
    end
  end

  // region write pointer, wraps at 32
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (i_gnt) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // frame counters, judged on the tlast beat
  // non-matching beats are simply consumed
  always_ff @(posedge clk) begin
    if (rst) begin
      kept_cnt <= '0;
      drop_cnt <= '0;
    end else if (accept && i_tlast) begin
      if (dest_match) begin
        kept_cnt <= kept_cnt + 1'b1;
      end else begin
        drop_cnt <= drop_cnt + 1'b1;
      end
    end
  end

  assign o_req = hold_valid;
  assign o_off = wr_ptr;
  assign o_data = hold_data;

  assign o_kept = kept_cnt;
  assign o_dropped = drop_cnt;
  assign o_ptr = wr_ptr;

endmodule

// File: hw/buf_write_arbiter.sv
/*
 * round-robin arbiter for the single capture buffer write port,
 * address built from the granted channel and its region offset
 */

module buf_write_arbiter (
  input  logic                                   clk,
  input  logic                                   rst,

  // channel 0 request
  input  logic                                   i_req0,
  input  logic [stream_cfg_pkg::REGION_AW-1:0]   i_off0,
  input  logic [stream_cfg_pkg::DATA_W-1:0]      i_data0,

  // channel 1 request
  input  logic                                   i_req1,
  input  logic [stream_cfg_pkg::REGION_AW-1:0]   i_off1,
  input  logic [stream_cfg_pkg::DATA_W-1:0]      i_data1,

  output logic                                   o_gnt0,
  output logic                                   o_gnt1,

  // buffer write port
  output logic                                   o_wr_en,
  output logic [stream_cfg_pkg::BUF_AW-1:0]      o_wr_addr,
  output logic [stream_cfg_pkg::DATA_W-1:0]      o_wr_data
);

  logic [stream_cfg_pkg::NUM_CH-1:0]      req;
  logic [stream_cfg_pkg::NUM_CH-1:0]      gnt;
  logic                                   last_gnt1;
  logic [stream_cfg_pkg::REGION_AW-1:0]   sel_off;

  assign req = {i_req1, i_req0};

  // one grant per cycle
  // on a tie the channel not served last wins
  always_comb begin
    gnt = '0;
    case (req)
      2'b01: gnt = 2'b01;
      2'b10: gnt = 2'b10;
      2'b11: gnt = last_gnt1 ? 2'b01 : 2'b10;
      default: gnt = '0;
    endcase
  end

  // remember who was served
  always_ff @(posedge clk) begin
    if (rst) begin
      last_gnt1 <= 1'b0;
    end else if (|gnt) begin
      last_gnt1 <= gnt[1];
    end
  end

  assign o_gnt0 = gnt[0];
  assign o_gnt1 = gnt[1];

  // channel index is the buffer address msb
  assign sel_off = gnt[1] ? i_off1 : i_off0;
  assign o_wr_en = |gnt;
  assign o_wr_addr = {gnt[1], sel_off};
  assign o_wr_data = gnt[1] ? i_data1 : i_data0;

endmodule

// File: hw/capture_buffer.sv
/*
 * 64 word capture memory, one synchronous write port
 * and one registered read port
 */

module capture_buffer (
  input  logic                                clk,

  input  logic                                i_wr_en,
  input  logic [stream_cfg_pkg::BUF_AW-1:0]   i_wr_addr,
  input  logic [stream_cfg_pkg::DATA_W-1:0]   i_wr_data,

  input  logic                                i_rd_en,
  input  logic [stream_cfg_pkg::BUF_AW-1:0]   i_rd_addr,
  output logic [stream_cfg_pkg::DATA_W-1:0]   o_rd_data
);

  logic [stream_cfg_pkg::DATA_W-1:0] mem [stream_cfg_pkg::BUF_DEPTH];

  // write side, fed by the arbiter
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // read side, data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

// File: hw/stream_capture_top.sv
/*
 * two-channel stream capture top: ingress blocks, write arbiter,
 * capture buffer and APB register slave
 */

module stream_capture_top (
  input  logic                                clk,
  input  logic                                rst,

  // stream channel 0
  input  logic                                i_s0_tvalid,
  output logic                                o_s0_tready,
  input  logic [stream_cfg_pkg::DATA_W-1:0]   i_s0_tdata,
  input  logic [stream_cfg_pkg::KEEP_W-1:0]   i_s0_tkeep,
  input  logic                                i_s0_tlast,
  input  logic [stream_cfg_pkg::TDEST_W-1:0]  i_s0_tdest,

  // stream channel 1
  input  logic                                i_s1_tvalid,
  output logic                                o_s1_tready,
  input  logic [stream_cfg_pkg::DATA_W-1:0]   i_s1_tdata,
  input  logic [stream_cfg_pkg::KEEP_W-1:0]   i_s1_tkeep,
  input  logic                                i_s1_tlast,
  input  logic [stream_cfg_pkg::TDEST_W-1:0]  i_s1_tdest,

  // APB
  input  logic                                i_psel,
  input  logic                                i_penable,
  input  logic                                i_pwrite,
  input  logic [stream_regs_pkg::APB_AW-1:0]  i_paddr,
  input  logic [stream_cfg_pkg::DATA_W-1:0]   i_pwdata,
  output logic [stream_cfg_pkg::DATA_W-1:0]   o_prdata,
  output logic                                o_pready,
  output logic                                o_pslverr
);

  // control from the register block
  logic                                  enable_0, enable_1;
  logic [stream_cfg_pkg::TDEST_W-1:0]    dest_0, dest_1;
  // ingress to arbiter
  logic                                  req_0, req_1, gnt_0, gnt_1;
  logic [stream_cfg_pkg::REGION_AW-1:0]  off_0, off_1, ptr_0, ptr_1;
  logic [stream_cfg_pkg::DATA_W-1:0]     data_0, data_1;
  logic [stream_cfg_pkg::CNT_W-1:0]      kept_0, kept_1, dropped_0, dropped_1;
  // buffer ports
  logic                                  wr_en, rd_en;
  logic [stream_cfg_pkg::BUF_AW-1:0]     wr_addr, rd_addr;
  logic [stream_cfg_pkg::DATA_W-1:0]     wr_data, rd_data;

  axis_ingress u_ingress0 (
    .clk(clk), .rst(rst), .i_enable(enable_0), .i_dest(dest_0),
    .i_tvalid(i_s0_tvalid), .o_tready(o_s0_tready), .i_tdata(i_s0_tdata),
    .i_tkeep(i_s0_tkeep), .i_tlast(i_s0_tlast), .i_tdest(i_s0_tdest),
    .o_req(req_0), .o_off(off_0), .o_data(data_0), .i_gnt(gnt_0),
    .o_kept(kept_0), .o_dropped(dropped_0), .o_ptr(ptr_0)
  );

  axis_ingress u_ingress1 (
    .clk(clk), .rst(rst), .i_enable(enable_1), .i_dest(dest_1),
    .i_tvalid(i_s1_tvalid), .o_tready(o_s1_tready), .i_tdata(i_s1_tdata),
    .i_tkeep(i_s1_tkeep), .i_tlast(i_s1_tlast), .i_tdest(i_s1_tdest),
    .o_req(req_1), .o_off(off_1), .o_data(data_1), .i_gnt(gnt_1),
    .o_kept(kept_1), .o_dropped(dropped_1), .o_ptr(ptr_1)
  );

  // shared write port
  buf_write_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .i_req0(req_0), .i_off0(off_0), .i_data0(data_0),
    .i_req1(req_1), .i_off1(off_1), .i_data1(data_1),
    .o_gnt0(gnt_0), .o_gnt1(gnt_1),
    .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
  );

  capture_buffer u_buffer (
    .clk(clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
    .i_rd_en(rd_en), .i_rd_addr(rd_addr), .o_rd_data(rd_data)
  );

  apb_capture_regs u_regs (
    .clk(clk), .rst(rst),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
    .o_enable0(enable_0), .o_dest0(dest_0), .o_enable1(enable_1), .o_dest1(dest_1),
    .i_kept0(kept_0), .i_dropped0(dropped_0), .i_ptr0(ptr_0),
    .i_kept1(kept_1), .i_dropped1(dropped_1), .i_ptr1(ptr_1),
    .o_rd_en(rd_en), .o_rd_addr(rd_addr), .i_rd_data(rd_data)
  );

endmodule

// File: hw/stream_cfg_pkg.sv
/*
 * data path widths, channel count and capture buffer geometry
 * for the two-channel stream capture unit
 */

package stream_cfg_pkg;

  // stream word and buffer word are the same width
  localparam int DATA_W = 32;
  // one keep bit per byte
  localparam int KEEP_W = DATA_W / 8;

  // tdest match field
  localparam int TDEST_W = 4;

  // ingress channels sharing the buffer
  localparam int NUM_CH = 2;

  // 64 word buffer, split in two 32 word regions
  localparam int BUF_AW = 6;
  localparam int BUF_DEPTH = 1 << BUF_AW;
  // per-channel offset, msb of buffer address picks the channel
  localparam int REGION_AW = 5;

  // kept and dropped frame counters, wrap at 256
  localparam int CNT_W = 8;

endpackage

// File: hw/stream_regs_pkg.sv
/*
 * APB address map and register field positions
 * for the stream capture control and status block
 */

package stream_regs_pkg;

  // byte address, buffer window needs the top bit
  localparam int APB_AW = 9;

  // per-channel control, enable and dest match
  localparam logic [APB_AW-1:0] ADDR_CTRL0 = 9'h000;
  localparam logic [APB_AW-1:0] ADDR_CTRL1 = 9'h004;

  // per-channel status, read only
  localparam logic [APB_AW-1:0] ADDR_STAT0 = 9'h008;
  localparam logic [APB_AW-1:0] ADDR_STAT1 = 9'h00C;

  // read-only buffer window, word n at base + 4n
  // words 32..63 hold channel 1
  localparam logic [APB_AW-1:0] BUF_WIN_BASE = 9'h100;

  // control register fields
  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_DEST_LSB = 4;

  // status register fields
  localparam int STAT_KEPT_LSB = 0;
  localparam int STAT_DROP_LSB = 8;
  localparam int STAT_PTR_LSB = 16;

endpackage

// File: verification/tb_stream_capture_checks.svh
/*
 * compare tasks for buffer words, frame counts, write pointers
 * and error flags, plus the LCG behind the stream data
 */

`ifndef TB_STREAM_CAPTURE_CHECKS_SVH
`define TB_STREAM_CAPTURE_CHECKS_SVH

// LCG state, fixed seed
logic [stream_cfg_pkg::DATA_W-1:0] lcg_state = 32'd67;

// next pseudo-random data word
function automatic logic [stream_cfg_pkg::DATA_W-1:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// buffer words and whole register words
task automatic check_word(input string name,
                          input logic [stream_cfg_pkg::DATA_W-1:0] expected,
                          input logic [stream_cfg_pkg::DATA_W-1:0] actual);
  if (actual !== expected) begin
    report_failure($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
  end
endtask

// kept and dropped frame counts
task automatic check_count(input string name,
                           input logic [stream_cfg_pkg::CNT_W-1:0] expected,
                           input logic [stream_cfg_pkg::CNT_W-1:0] actual);
  if (actual !== expected) begin
    report_failure($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
  end
endtask

// region write pointers
task automatic check_ptr(input string name,
                         input logic [stream_cfg_pkg::REGION_AW-1:0] expected,
                         input logic [stream_cfg_pkg::REGION_AW-1:0] actual);
  if (actual !== expected) begin
    report_failure($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
  end
endtask

// APB slave error flag
task automatic check_err(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    report_failure($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
  end
endtask

`endif

// File: verification/tb_stream_capture.sv
/*
 * testbench for the two-channel stream capture unit: clock, reset,
 * frame table, stream and APB drivers, buffer reference model, timeout
 */

module tb_stream_capture;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 6;
  localparam int REGION_WORDS = 1 << stream_cfg_pkg::REGION_AW;
  // APB access allowance in the cycle limit
  localparam int APB_OPS = 40;
  localparam logic [3:0] CFG_DEST = 4'd3;
  localparam logic [31:0] CTRL_VALUE =
    (CFG_DEST << stream_regs_pkg::CTRL_DEST_LSB) | (1 << stream_regs_pkg::CTRL_EN_BIT);

  typedef struct {
    string                                name;
    logic [1:0]                           mask;
    int                                   beats;
    logic [stream_cfg_pkg::TDEST_W-1:0]   tdest;
    logic [stream_cfg_pkg::KEEP_W-1:0]    last_keep;
    logic                                 kept;
  } frame_row_t;

  // name, channel mask, beats, tdest, last-beat tkeep, kept
  frame_row_t frame_table [NUM_ROWS] = '{
    '{"ch0_keep_a", 2'b01,  4, 4'd3, 4'b0011, 1'b1},
    '{"ch0_keep_b", 2'b01,  3, 4'd3, 4'b0001, 1'b1},
    '{"ch0_drop",   2'b01,  3, 4'd7, 4'b1111, 1'b0},
    '{"both_keep",  2'b11,  6, 4'd3, 4'b0111, 1'b1},
    '{"ch1_wrap_a", 2'b10, 20, 4'd3, 4'b1111, 1'b1},
    '{"ch1_wrap_b", 2'b10, 16, 4'd3, 4'b1000, 1'b1}
  };

  logic clk;
  logic rst;
  logic [1:0] s_tvalid;
  wire  [1:0] s_tready;
  logic [1:0] s_tlast;
  logic [stream_cfg_pkg::DATA_W-1:0] s_tdata [2];
  logic [stream_cfg_pkg::KEEP_W-1:0] s_tkeep [2];
  logic [stream_cfg_pkg::TDEST_W-1:0] s_tdest [2];
  logic psel;
  logic penable;
  logic pwrite;
  logic [stream_regs_pkg::APB_AW-1:0] paddr;
  logic [stream_cfg_pkg::DATA_W-1:0] pwdata;
  wire  [stream_cfg_pkg::DATA_W-1:0] prdata;
  wire  pready;
  wire  pslverr;

  // reference model: buffer image, per-channel pointer and counts
  logic [stream_cfg_pkg::DATA_W-1:0] mdl_mem [stream_cfg_pkg::BUF_DEPTH];
  logic mdl_written [stream_cfg_pkg::BUF_DEPTH];
  logic [stream_cfg_pkg::REGION_AW-1:0] mdl_ptr [2];
  logic [stream_cfg_pkg::CNT_W-1:0] mdl_kept [2];
  logic [stream_cfg_pkg::CNT_W-1:0] mdl_drop [2];
  logic [stream_cfg_pkg::DATA_W-1:0] frame_words [2][REGION_WORDS];
  int cycle_count = 0;
  int cycle_limit;

  stream_capture_top stream_capture_top_inst (
    .clk(clk), .rst(rst),
    .i_s0_tvalid(s_tvalid[0]), .o_s0_tready(s_tready[0]), .i_s0_tdata(s_tdata[0]),
    .i_s0_tkeep(s_tkeep[0]), .i_s0_tlast(s_tlast[0]), .i_s0_tdest(s_tdest[0]),
    .i_s1_tvalid(s_tvalid[1]), .o_s1_tready(s_tready[1]), .i_s1_tdata(s_tdata[1]),
    .i_s1_tkeep(s_tkeep[1]), .i_s1_tlast(s_tlast[1]), .i_s1_tdest(s_tdest[1]),
    .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
    .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
  );

  `include "tb_stream_capture_checks.svh"

  always #5 clk = ~clk;

  // run limit, counted in rising edges
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      report_failure($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  // bytes with a clear keep bit read back as zero
  function automatic logic [stream_cfg_pkg::DATA_W-1:0] apply_keep(
      input logic [stream_cfg_pkg::DATA_W-1:0] data,
      input logic [stream_cfg_pkg::KEEP_W-1:0] keep);
    logic [stream_cfg_pkg::DATA_W-1:0] res;
    res = '0;
    for (int b = 0; b < stream_cfg_pkg::KEEP_W; b++) begin
      if (keep[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  // one APB transfer, entered and left on a falling edge
  // register access ends in the first access cycle and a buffer read in the second
  task automatic apb_access(input logic write, input logic [stream_regs_pkg::APB_AW-1:0] addr,
                            input logic [stream_cfg_pkg::DATA_W-1:0] wdata,
                            output logic [stream_cfg_pkg::DATA_W-1:0] rdata,
                            output logic err);
    logic buf_read;
    buf_read = !write && (addr >= stream_regs_pkg::BUF_WIN_BASE);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    // pready settles just after the falling edge
    #1;
    if (buf_read) begin
      if (pready !== 1'b0) begin
        report_failure("pready came high in the first access cycle of a buffer read");
      end
      @(negedge clk);
      #1;
    end
    if (pready !== 1'b1) begin
      report_failure("pready was low in the cycle where the APB transfer should complete");
    end
    rdata = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_and_compare(input string name, input logic [stream_regs_pkg::APB_AW-1:0] addr,
                                  input logic [stream_cfg_pkg::DATA_W-1:0] expected,
                                  input logic expected_err);
    logic [stream_cfg_pkg::DATA_W-1:0] word;
    logic err;
    apb_access(1'b0, addr, '0, word, err);
    check_err(name, expected_err, err);
    check_word(name, expected, word);
  endtask

  task automatic check_status(input string name, input int ch);
    logic [stream_cfg_pkg::DATA_W-1:0] word;
    logic err;
    apb_access(1'b0, ch ? stream_regs_pkg::ADDR_STAT1 : stream_regs_pkg::ADDR_STAT0, '0, word, err);
    check_err(name, 1'b0, err);
    check_count(name, mdl_kept[ch], word[stream_regs_pkg::STAT_KEPT_LSB +: stream_cfg_pkg::CNT_W]);
    check_count(name, mdl_drop[ch], word[stream_regs_pkg::STAT_DROP_LSB +: stream_cfg_pkg::CNT_W]);
    check_ptr(name, mdl_ptr[ch], word[stream_regs_pkg::STAT_PTR_LSB +: stream_cfg_pkg::REGION_AW]);
  endtask

  // one frame on one channel, model updated per accepted beat
  task automatic drive_frame(input int ch, input int row);
    int i;
    int idx;
    logic last;
    logic [stream_cfg_pkg::KEEP_W-1:0] keep;
    for (i = 0; i < frame_table[row].beats; i++) begin
      last = (i == frame_table[row].beats - 1);
      keep = last ? frame_table[row].last_keep : '1;
      s_tvalid[ch] = 1'b1;
      s_tdata[ch] = frame_words[ch][i];
      s_tkeep[ch] = keep;
      s_tlast[ch] = last;
      s_tdest[ch] = frame_table[row].tdest;
      // tready moves only on rising edges
      while (!s_tready[ch]) @(negedge clk);
      @(negedge clk);
      if (frame_table[row].kept) begin
        idx = ch * REGION_WORDS + mdl_ptr[ch];
        mdl_mem[idx] = apply_keep(frame_words[ch][i], keep);
        mdl_written[idx] = 1'b1;
        mdl_ptr[ch] = mdl_ptr[ch] + 1'b1;
      end
    end
    s_tvalid[ch] = 1'b0;
    if (frame_table[row].kept) mdl_kept[ch] = mdl_kept[ch] + 1'b1;
    else mdl_drop[ch] = mdl_drop[ch] + 1'b1;
  endtask

  initial begin
    logic [stream_cfg_pkg::DATA_W-1:0] rd_word;
    logic rd_err;
    cycle_limit = APB_OPS * 4 + 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycle_limit += frame_table[r].beats * (frame_table[r].mask[0] + frame_table[r].mask[1]) * 4;
    end
    for (int n = 0; n < stream_cfg_pkg::BUF_DEPTH; n++) mdl_written[n] = 1'b0;
    for (int c = 0; c < 2; c++) begin
      mdl_ptr[c] = '0;
      mdl_kept[c] = '0;
      mdl_drop[c] = '0;
      s_tdata[c] = '0;
      s_tkeep[c] = '0;
      s_tdest[c] = '0;
    end
    clk = 1'b0;
    rst = 1'b1;
    s_tvalid = '0;
    s_tlast = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // reset state
    if (s_tready !== 2'b00) report_failure("stream tready is high right after reset");
    read_and_compare("reset_ctrl0", stream_regs_pkg::ADDR_CTRL0, '0, 1'b0);
    read_and_compare("reset_ctrl1", stream_regs_pkg::ADDR_CTRL1, '0, 1'b0);
    read_and_compare("reset_stat0", stream_regs_pkg::ADDR_STAT0, '0, 1'b0);
    read_and_compare("reset_stat1", stream_regs_pkg::ADDR_STAT1, '0, 1'b0);

    // disabled channel holds the beat off
    s_tvalid[0] = 1'b1;
    s_tdata[0] = lcg_next();
    s_tkeep[0] = '1;
    s_tlast[0] = 1'b1;
    s_tdest[0] = CFG_DEST;
    repeat (4) begin
      if (s_tready[0] !== 1'b0) report_failure("channel 0 took a beat while disabled");
      @(negedge clk);
    end
    s_tvalid[0] = 1'b0;
    check_status("ch0_disabled", 0);

    apb_access(1'b1, stream_regs_pkg::ADDR_CTRL0, CTRL_VALUE, rd_word, rd_err);
    check_err("cfg_ctrl0", 1'b0, rd_err);
    apb_access(1'b1, stream_regs_pkg::ADDR_CTRL1, CTRL_VALUE, rd_word, rd_err);
    check_err("cfg_ctrl1", 1'b0, rd_err);

    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < 2; c++) begin
        for (int i = 0; i < frame_table[r].beats; i++) begin
          if (frame_table[r].mask[c]) frame_words[c][i] = lcg_next();
        end
      end
      fork
        if (frame_table[r].mask[0]) drive_frame(0, r);
        if (frame_table[r].mask[1]) drive_frame(1, r);
      join
      // holding stages drain before the status read
      for (int c = 0; c < 2; c++) begin
        while (frame_table[r].mask[c] && !s_tready[c]) @(negedge clk);
      end
      check_status(frame_table[r].name, 0);
      check_status(frame_table[r].name, 1);
    end

    // window write and unmapped read are both errors
    apb_access(1'b1, stream_regs_pkg::BUF_WIN_BASE, 32'hdead_beef, rd_word, rd_err);
    check_err("window_write", 1'b1, rd_err);
    read_and_compare("unmapped_read", 9'h040, '0, 1'b1);
    read_and_compare("ctrl0_after_err", stream_regs_pkg::ADDR_CTRL0, CTRL_VALUE, 1'b0);
    read_and_compare("ctrl1_after_err", stream_regs_pkg::ADDR_CTRL1, CTRL_VALUE, 1'b0);

    // every word the model wrote, both regions
    for (int n = 0; n < stream_cfg_pkg::BUF_DEPTH; n++) begin
      if (mdl_written[n]) begin
        read_and_compare($sformatf("buffer_word_%0d", n),
                         stream_regs_pkg::BUF_WIN_BASE + 9'(4 * n), mdl_mem[n], 1'b0);
      end
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verification
hw/stream_cfg_pkg.sv
hw/stream_regs_pkg.sv
hw/axis_ingress.sv
hw/buf_write_arbiter.sv
hw/capture_buffer.sv
hw/apb_capture_regs.sv
hw/stream_capture_top.sv
verification/tb_stream_capture.sv
